//--- Bender.yml
package:
  name: lc3b_pipeline

sources:
  - logic/lc3b_types.sv
  - logic/fetch.sv
  - logic/decode.sv
  - logic/execute.sv
  - logic/mem_access.sv
  - logic/arbiter.sv
  - logic/mp3.sv
  - target: simulation
    files:
      - bench/clock_gen.sv
      - bench/mp3_checker.sv
      - bench/mp3_tb.sv

//--- bench/clock_gen.sv
`timescale 1ns/1ns

module clock_gen (
	input logic reset_req,
	output logic clk,
	output logic arst_n
);

logic [3:0] count;

initial begin
	clk = 1'b0;
	arst_n = 1'b1;
	count = 4'd0;
	// reset falls just after time zero
	#1 arst_n = 1'b0;
	forever #4 clk = ~clk;
end

// reset changes on the falling edge, away from the sampling edge
always @(negedge clk) begin
	if (reset_req) begin
		count <= 4'd0;
		arst_n <= 1'b0;
	end else if (count < 4'd10) begin
		count <= count + 4'd1;
		arst_n <= (count == 4'd9);
	end
end

endmodule : clock_gen

//--- bench/mp3_checker.sv
`timescale 1ns/1ns

module mp3_checker (
	input logic clk,
	input logic arst_n,
	input logic pmem_read,
	input logic pmem_write,
	input logic pmem_resp,
	input lc3b_types::lc3b_word pmem_address,
	input lc3b_types::lc3b_word pmem_wdata
);

int fail_count = 0;

never_both: assert property (@(posedge clk) disable iff (!arst_n)
	!(pmem_read && pmem_write))
	else begin
		fail_count++;
		$error("pmem_read and pmem_write high together");
	end

// request and address held until the response
read_held: assert property (@(posedge clk) disable iff (!arst_n)
	pmem_read && !pmem_resp |=> pmem_read && $stable(pmem_address))
	else begin
		fail_count++;
		$error("read request dropped or address moved before pmem_resp");
	end

write_held: assert property (@(posedge clk) disable iff (!arst_n)
	pmem_write && !pmem_resp |=> pmem_write && $stable(pmem_address) && $stable(pmem_wdata))
	else begin
		fail_count++;
		$error("write request dropped or address/data moved before pmem_resp");
	end

released: assert property (@(posedge clk) disable iff (!arst_n)
	pmem_resp |=> !pmem_read && !pmem_write)
	else begin
		fail_count++;
		$error("request still high in the cycle after pmem_resp");
	end

quiet_in_reset: assert property (@(posedge clk)
	!arst_n |-> !pmem_read && !pmem_write)
	else begin
		fail_count++;
		$error("memory request active during reset");
	end

endmodule : mp3_checker

bind mp3 mp3_checker checker_i (
	.clk,
	.arst_n,
	.pmem_read,
	.pmem_write,
	.pmem_resp,
	.pmem_address,
	.pmem_wdata
);

//--- bench/mp3_tb.sv
`timescale 1ns/1ns

module mp3_tb;

localparam lc3b_types::lc3b_word RESET_PC = 16'h0100;
localparam int NUM_TESTS = 8;
localparam int BODY_LEN = 40;
localparam int DATA_WORDS = 32;
localparam int RUN_TIMEOUT = 20000;

logic clk;
logic arst_n;
logic reset_req = 1'b0;
logic pmem_resp = 1'b0;
lc3b_types::lc3b_word pmem_rdata = 16'h0000;
logic pmem_read;
logic pmem_write;
lc3b_types::lc3b_word pmem_address;
lc3b_types::lc3b_word pmem_wdata;

lc3b_types::lc3b_word mem [32768];
lc3b_types::lc3b_word model_mem [32768];
lc3b_types::lc3b_word prog [$];
lc3b_types::lc3b_word exp_addr [$];
lc3b_types::lc3b_word exp_data [$];

integer seed = 32'h4b96faa9;
int error_count = 0;
int failed_tests = 0;
int store_count = 0;
int assert_fails = 0;
logic busy = 1'b0;
int unsigned wait_cnt = 0;
logic first_seen = 1'b0;
logic first_write;
lc3b_types::lc3b_word first_addr;

clock_gen clock_gen_i (
	.reset_req,
	.clk,
	.arst_n
);

mp3 #(.RESET_PC(RESET_PC)) dut_i (
	.clk,
	.arst_n,
	.pmem_resp,
	.pmem_rdata,
	.pmem_read,
	.pmem_write,
	.pmem_address,
	.pmem_wdata
);

function automatic int unsigned rand_below(input int unsigned n);
	return $unsigned($random(seed)) % n;
endfunction

function automatic logic [2:0] cc_of(input lc3b_types::lc3b_word value);
	return {value[15], value == 16'h0000, !value[15] && value != 16'h0000};
endfunction

task automatic check_store(input lc3b_types::lc3b_word addr, input lc3b_types::lc3b_word data);
	if (store_count >= exp_addr.size()) begin
		$display("Error at %0t: unexpected store of %h to %h", $time, data, addr);
		error_count++;
	end else begin
		if (addr !== exp_addr[store_count]) begin
			$display("Error at %0t: store %0d went to %h, expected %h", $time,
				store_count, addr, exp_addr[store_count]);
			error_count++;
		end
		if (data !== exp_data[store_count]) begin
			$display("Error at %0t: store %0d wrote %h, expected %h", $time,
				store_count, data, exp_data[store_count]);
			error_count++;
		end
	end
	store_count++;
endtask

// word memory, answers on the falling edge after 0 to 5 cycles
always @(negedge clk) begin
	if (!arst_n) begin
		pmem_resp <= 1'b0;
		busy = 1'b0;
	end else if (pmem_resp) begin
		pmem_resp <= 1'b0;
	end else if (pmem_read || pmem_write) begin
		if (!busy) begin
			busy = 1'b1;
			wait_cnt = rand_below(6);
			if (!first_seen) begin
				first_seen = 1'b1;
				first_addr = pmem_address;
				first_write = pmem_write;
			end
		end
		if (wait_cnt == 0) begin
			busy = 1'b0;
			pmem_resp <= 1'b1;
			if (pmem_write) begin
				check_store(pmem_address, pmem_wdata);
				mem[pmem_address[15:1]] = pmem_wdata;
			end else begin
				pmem_rdata <= mem[pmem_address[15:1]];
			end
		end else begin
			wait_cnt--;
		end
	end
end

task automatic build_program();
	lc3b_types::lc3b_word word;
	logic [2:0] dr;
	logic [2:0] src;
	int unsigned kind;
	int i;
	prog.delete();
	// clear all registers, seed r0..r6; r7 stays zero as the data base
	for (i = 0; i < 8; i++)
		prog.push_back({4'b0101, 3'(i), 3'(i), 6'b100000});
	for (i = 0; i < 7; i++)
		prog.push_back({4'b0001, 3'(i), 3'(i), 1'b1, 5'(rand_below(32))});
	for (i = 0; i < BODY_LEN; i++) begin
		kind = rand_below(8);
		dr = 3'(rand_below(7));
		src = 3'(rand_below(8));
		case (kind)
			0: word = {4'b0001, dr, src, 3'b000, 3'(rand_below(8))};
			1: word = {4'b0001, dr, src, 1'b1, 5'(rand_below(32))};
			2: word = {4'b0101, dr, src, 3'b000, 3'(rand_below(8))};
			3: word = {4'b0101, dr, src, 1'b1, 5'(rand_below(32))};
			4: word = {4'b1001, dr, src, 6'b111111};
			5: word = {4'b0110, dr, 3'd7, 1'b0, 5'(rand_below(DATA_WORDS))};
			6: word = {4'b0111, src, 3'd7, 1'b0, 5'(rand_below(DATA_WORDS))};
			// forward branch skipping up to three words
			default: word = {4'b0000, src, 7'b0000000, 2'(rand_below(4))};
		endcase
		prog.push_back(word);
		if (kind < 6 && rand_below(2) == 1)
			prog.push_back({4'b0111, dr, 3'd7, 1'b0, 5'(rand_below(DATA_WORDS))});
	end
	// landing pad of never-taken branches, then branch to self
	for (i = 0; i < 3; i++)
		prog.push_back(16'h0000);
	prog.push_back(16'h0FFF);

	for (i = 0; i < 32768; i++)
		mem[i] = 16'(i) ^ 16'hc35a;
	for (i = 0; i < DATA_WORDS; i++)
		mem[i] = 16'($random(seed));
	for (i = 0; i < prog.size(); i++)
		mem[int'(RESET_PC[15:1]) + i] = prog[i];
	for (i = 0; i < 32768; i++)
		model_mem[i] = mem[i];
endtask

// ISA model, collects the ordered stores
task automatic run_model();
	lc3b_types::lc3b_word r [8];
	lc3b_types::lc3b_word pc;
	lc3b_types::lc3b_word ir;
	lc3b_types::lc3b_word addr;
	lc3b_types::lc3b_word val;
	logic [2:0] cc;
	logic wr;
	int steps;
	int i;
	for (i = 0; i < 8; i++)
		r[i] = 16'h0000;
	cc = 3'b010;
	pc = RESET_PC;
	steps = 0;
	exp_addr.delete();
	exp_data.delete();
	ir = model_mem[pc[15:1]];
	while (ir != 16'h0FFF && steps < 1000) begin
		pc = pc + 16'd2;
		wr = 1'b0;
		addr = r[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0};
		case (ir[15:12])
			4'b0001: begin
				val = r[ir[8:6]] + (ir[5] ? {{11{ir[4]}}, ir[4:0]} : r[ir[2:0]]);
				wr = 1'b1;
			end
			4'b0101: begin
				val = r[ir[8:6]] & (ir[5] ? {{11{ir[4]}}, ir[4:0]} : r[ir[2:0]]);
				wr = 1'b1;
			end
			4'b1001: begin
				val = ~r[ir[8:6]];
				wr = 1'b1;
			end
			4'b0110: begin
				val = model_mem[addr[15:1]];
				wr = 1'b1;
			end
			4'b0111: begin
				model_mem[addr[15:1]] = r[ir[11:9]];
				exp_addr.push_back(addr);
				exp_data.push_back(r[ir[11:9]]);
			end
			4'b0000: begin
				if ((ir[11:9] & cc) != 3'b000)
					pc = pc + {{6{ir[8]}}, ir[8:0], 1'b0};
			end
			default: ;
		endcase
		if (wr) begin
			r[ir[11:9]] = val;
			cc = cc_of(val);
		end
		ir = model_mem[pc[15:1]];
		steps++;
	end
	if (steps >= 1000) begin
		$display("reference model never reached the closing branch");
		error_count++;
	end
endtask

task automatic run_test(input int num);
	int cycles;
	int errs_before;
	errs_before = error_count;

	@(negedge clk);
	reset_req <= 1'b1;
	@(negedge clk);
	reset_req <= 1'b0;
	cycles = 0;
	while (arst_n && cycles < 20) begin
		@(negedge clk);
		cycles++;
	end
	if (arst_n) begin
		$display("test %0d: reset was never asserted", num);
		error_count++;
	end

	// memory is idle while the core is held in reset
	build_program();
	run_model();
	store_count = 0;
	first_seen = 1'b0;

	cycles = 0;
	while (!arst_n && cycles < 40) begin
		if (pmem_read || pmem_write) begin
			$display("Error at %0t: memory request during reset", $time);
			error_count++;
		end
		@(negedge clk);
		cycles++;
	end
	if (!arst_n) begin
		$display("test %0d: reset was never released", num);
		error_count++;
	end

	cycles = 0;
	while (store_count < exp_addr.size() && cycles < RUN_TIMEOUT) begin
		@(posedge clk);
		cycles++;
	end
	if (store_count < exp_addr.size()) begin
		$display("test %0d: timed out with %0d of %0d stores seen", num,
			store_count, exp_addr.size());
		error_count++;
	end

	// any late store from a skipped instruction lands here
	cycles = 0;
	while (cycles < 50) begin
		@(posedge clk);
		cycles++;
	end

	if (!first_seen || first_write || first_addr !== RESET_PC) begin
		$display("Error at %0t: first request after reset was not a read of %h", $time,
			RESET_PC);
		error_count++;
	end

	if (dut_i.checker_i.fail_count != assert_fails) begin
		$display("test %0d: %0d bus protocol assertions failed", num,
			dut_i.checker_i.fail_count - assert_fails);
		error_count += dut_i.checker_i.fail_count - assert_fails;
		assert_fails = dut_i.checker_i.fail_count;
	end

	if (error_count == errs_before) begin
		$display("test %0d: passed, %0d instructions, %0d stores", num, prog.size(),
			exp_addr.size());
	end else begin
		$display("test %0d: failed with %0d errors", num, error_count - errs_before);
		failed_tests++;
	end
endtask

initial begin
	int t;
	for (t = 0; t < NUM_TESTS; t++)
		run_test(t);
	$display("%0d tests run, %0d passed, %0d failed, %0d errors", NUM_TESTS,
		NUM_TESTS - failed_tests, failed_tests, error_count);
	if (failed_tests == 0 && error_count == 0 && dut_i.checker_i.fail_count == 0)
		$display("ALL TESTS PASSED");
	else
		$display("SOME TESTS FAILED");
	$finish;
end

endmodule : mp3_tb

//--- filelist.f
logic/lc3b_types.sv
logic/fetch.sv
logic/decode.sv
logic/execute.sv
logic/mem_access.sv
logic/arbiter.sv
logic/mp3.sv
bench/clock_gen.sv
bench/mp3_checker.sv
bench/mp3_tb.sv

//--- logic/arbiter.sv
`timescale 1ns/1ns

module arbiter (
	input logic clk,
	input logic arst_n,

	input logic if_read,
	input lc3b_types::lc3b_word if_address,

	input logic d_read,
	input logic d_write,
	input lc3b_types::lc3b_word d_address,
	input lc3b_types::lc3b_word d_wdata,

	input logic pmem_resp,
	input lc3b_types::lc3b_word pmem_rdata,

	output logic if_resp,
	output lc3b_types::lc3b_word if_rdata,
	output logic d_resp,
	output lc3b_types::lc3b_word d_rdata,

	output logic pmem_read,
	output logic pmem_write,
	output lc3b_types::lc3b_word pmem_address,
	output lc3b_types::lc3b_word pmem_wdata
);

lc3b_types::arb_state state;
logic d_req;

assign d_req = d_read || d_write;

// resp goes only to the side holding the grant
assign if_resp = (state == lc3b_types::arb_ifetch) && pmem_resp;
assign d_resp = (state == lc3b_types::arb_data) && pmem_resp;
assign if_rdata = pmem_rdata;
assign d_rdata = pmem_rdata;

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		state <= lc3b_types::arb_idle;
		pmem_read <= 1'b0;
		pmem_write <= 1'b0;
	end else begin
		case (state)
			lc3b_types::arb_idle: begin
				// data side first
				if (d_req) begin
					state <= lc3b_types::arb_data;
					pmem_read <= d_read;
					pmem_write <= d_write;
				end else if (if_read) begin
					state <= lc3b_types::arb_ifetch;
					pmem_read <= 1'b1;
				end
			end
			lc3b_types::arb_ifetch, lc3b_types::arb_data: begin
				if (pmem_resp) begin
					state <= lc3b_types::arb_idle;
					pmem_read <= 1'b0;
					pmem_write <= 1'b0;
				end
			end
			default: state <= lc3b_types::arb_idle;
		endcase
	end
end

// address and data captured at grant, stable until resp
always_ff @(posedge clk) begin
	if (state == lc3b_types::arb_idle) begin
		pmem_address <= d_req ? d_address : if_address;
		pmem_wdata <= d_wdata;
	end
end

endmodule : arbiter

//--- logic/decode.sv
`timescale 1ns/1ns

module decode (
	input logic clk,
	input logic arst_n,

	input lc3b_types::lc3b_word fd_pc,
	input lc3b_types::lc3b_word fd_ir,
	input logic fd_valid,
	input logic br_taken,
	input logic de_advance,

	input logic em_valid,
	input lc3b_types::lc3b_reg em_dr,
	input lc3b_types::lc3b_opcode em_op,

	input logic wb_en,
	input lc3b_types::lc3b_reg wb_dr,
	input lc3b_types::lc3b_word wb_data,
	input logic wb_cc_en,

	output logic fd_advance,
	output lc3b_types::lc3b_word de_pc,
	output lc3b_types::lc3b_opcode de_op,
	output lc3b_types::lc3b_reg de_dr,
	output lc3b_types::lc3b_word de_sr1_val,
	output lc3b_types::lc3b_word de_sr2_val,
	output lc3b_types::lc3b_word de_imm,
	output lc3b_types::lc3b_nzp de_nzp,
	output logic de_valid
);

lc3b_types::lc3b_word regs [8];
lc3b_types::lc3b_nzp cc;
lc3b_types::lc3b_nzp cur_cc;
lc3b_types::lc3b_opcode opcode;
lc3b_types::lc3b_reg sr1;
lc3b_types::lc3b_reg sr2;
lc3b_types::lc3b_imm5 imm5;
lc3b_types::lc3b_offset6 off6;
lc3b_types::lc3b_offset9 off9;
lc3b_types::lc3b_word sext5;
lc3b_types::lc3b_word sext6;
lc3b_types::lc3b_word sext9;
lc3b_types::lc3b_word sr1_val;
lc3b_types::lc3b_word sr2_val;
logic known;
logic uses_sr1;
logic uses_sr2;
logic alu_imm;
logic de_wr;
logic em_wr;
logic raw_hazard;
logic cc_hazard;
logic stall;

function automatic lc3b_types::lc3b_nzp gen_cc(input lc3b_types::lc3b_word value);
	if (value[15])
		return 3'b100;
	else if (value == 16'h0000)
		return 3'b010;
	else
		return 3'b001;
endfunction

assign opcode = lc3b_types::lc3b_opcode'(fd_ir[15:12]);
assign sr1 = fd_ir[8:6];
// str reads its source from the dr field
assign sr2 = (opcode == lc3b_types::op_str) ? fd_ir[11:9] : fd_ir[2:0];
assign imm5 = fd_ir[4:0];
assign off6 = fd_ir[5:0];
assign off9 = fd_ir[8:0];
assign sext5 = imm5;
assign sext6 = off6;
assign sext9 = off9;
assign alu_imm = fd_ir[5] && (opcode == lc3b_types::op_add || opcode == lc3b_types::op_and);

always_comb begin
	known = 1'b1;
	uses_sr1 = 1'b0;
	uses_sr2 = 1'b0;
	case (opcode)
		lc3b_types::op_add, lc3b_types::op_and: begin
			uses_sr1 = 1'b1;
			uses_sr2 = !fd_ir[5];
		end
		lc3b_types::op_not, lc3b_types::op_ldr: uses_sr1 = 1'b1;
		lc3b_types::op_str: begin
			uses_sr1 = 1'b1;
			uses_sr2 = 1'b1;
		end
		lc3b_types::op_br: known = 1'b1;
		default: known = 1'b0;
	endcase
end

// writeback bypass, the write lands at the end of this cycle
assign sr1_val = (wb_en && wb_dr == sr1) ? wb_data : regs[sr1];
assign sr2_val = (wb_en && wb_dr == sr2) ? wb_data : regs[sr2];
assign cur_cc = wb_cc_en ? gen_cc(wb_data) : cc;

assign de_wr = de_valid && lc3b_types::writes_reg(de_op);
assign em_wr = em_valid && lc3b_types::writes_reg(em_op);
assign raw_hazard = (uses_sr1 && ((de_wr && de_dr == sr1) || (em_wr && em_dr == sr1)))
	|| (uses_sr2 && ((de_wr && de_dr == sr2) || (em_wr && em_dr == sr2)));
assign cc_hazard = (opcode == lc3b_types::op_br) && (de_wr || em_wr);
assign stall = fd_valid && known && (raw_hazard || cc_hazard);
assign fd_advance = !fd_valid || (de_advance && !stall);

always_ff @(posedge clk) begin
	if (wb_en)
		regs[wb_dr] <= wb_data;
end

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		cc <= 3'b010;
		de_valid <= 1'b0;
	end else begin
		if (wb_cc_en)
			cc <= gen_cc(wb_data);
		if (br_taken)
			de_valid <= 1'b0;
		else if (de_advance)
			de_valid <= fd_valid && known && !stall;
	end
end

always_ff @(posedge clk) begin
	if (de_advance) begin
		de_pc <= fd_pc;
		de_op <= opcode;
		de_dr <= fd_ir[11:9];
		de_sr1_val <= sr1_val;
		de_sr2_val <= alu_imm ? sext5 : sr2_val;
		de_imm <= (opcode == lc3b_types::op_br) ? sext9 : sext6;
		de_nzp <= fd_ir[11:9] & cur_cc;
	end
end

endmodule : decode

//--- logic/execute.sv
`timescale 1ns/1ns

module execute (
	input logic clk,
	input logic arst_n,

	input lc3b_types::lc3b_word de_pc,
	input lc3b_types::lc3b_opcode de_op,
	input lc3b_types::lc3b_reg de_dr,
	input lc3b_types::lc3b_word de_sr1_val,
	input lc3b_types::lc3b_word de_sr2_val,
	input lc3b_types::lc3b_word de_imm,
	input lc3b_types::lc3b_nzp de_nzp,
	input logic de_valid,
	input logic em_advance,

	output logic de_advance,
	output logic br_taken,
	output lc3b_types::lc3b_word br_target,

	output lc3b_types::lc3b_opcode em_op,
	output lc3b_types::lc3b_reg em_dr,
	output lc3b_types::lc3b_word em_result,
	output lc3b_types::lc3b_word em_address,
	output lc3b_types::lc3b_word em_store_data,
	output logic em_valid
);

lc3b_types::lc3b_word offset;
lc3b_types::lc3b_word alu_out;
lc3b_types::lc3b_word address;

// word offsets
assign offset = {de_imm[14:0], 1'b0};
assign address = de_sr1_val + offset;
assign br_target = de_pc + 16'd2 + offset;

// de_nzp already holds the field masked by the current cc
assign br_taken = de_valid && (de_op == lc3b_types::op_br) && (de_nzp != 3'b000);

// an empty latch never holds decode back
assign de_advance = em_advance || !de_valid;

always_comb begin
	case (de_op)
		lc3b_types::op_add: alu_out = de_sr1_val + de_sr2_val;
		lc3b_types::op_and: alu_out = de_sr1_val & de_sr2_val;
		lc3b_types::op_not: alu_out = ~de_sr1_val;
		default: alu_out = de_sr1_val;
	endcase
end

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		em_valid <= 1'b0;
	end else if (em_advance) begin
		// branches end here, taken or not
		em_valid <= de_valid && (de_op != lc3b_types::op_br);
	end
end

always_ff @(posedge clk) begin
	if (em_advance) begin
		em_op <= de_op;
		em_dr <= de_dr;
		em_result <= alu_out;
		em_address <= address;
		em_store_data <= de_sr2_val;
	end
end

endmodule : execute

//--- logic/fetch.sv
`timescale 1ns/1ns

module fetch #(
	parameter lc3b_types::lc3b_word RESET_PC = 16'h0000
) (
	input logic clk,
	input logic arst_n,

	input logic br_taken,
	input lc3b_types::lc3b_word br_target,
	input logic fd_advance,

	input logic if_resp,
	input lc3b_types::lc3b_word if_rdata,
	output logic if_read,
	output lc3b_types::lc3b_word if_address,

	output lc3b_types::lc3b_word fd_pc,
	output lc3b_types::lc3b_word fd_ir,
	output logic fd_valid
);

lc3b_types::lc3b_word pc;
lc3b_types::lc3b_word hold_ir;
logic hold_valid;
logic drop;
logic resp_ok;
logic avail;

// word for the current pc, not one from before a redirect
assign resp_ok = if_resp && !drop && !br_taken;
assign avail = hold_valid || resp_ok;

// one word of buffering, no new read while it is full
assign if_read = !hold_valid;
assign if_address = pc;

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		pc <= RESET_PC;
		fd_valid <= 1'b0;
		hold_valid <= 1'b0;
		drop <= 1'b0;
	end else begin
		// read still in flight across a redirect
		if (br_taken && if_read && !if_resp)
			drop <= 1'b1;
		else if (if_resp)
			drop <= 1'b0;

		if (br_taken) begin
			pc <= br_target;
			fd_valid <= 1'b0;
			hold_valid <= 1'b0;
		end else if (fd_advance) begin
			fd_valid <= avail;
			hold_valid <= 1'b0;
			if (avail)
				pc <= pc + 16'd2;
		end else if (resp_ok) begin
			hold_valid <= 1'b1;
		end
	end
end

always_ff @(posedge clk) begin
	if (resp_ok)
		hold_ir <= if_rdata;
	if (fd_advance) begin
		fd_pc <= pc;
		fd_ir <= hold_valid ? hold_ir : if_rdata;
	end
end

endmodule : fetch

//--- logic/lc3b_types.sv
package lc3b_types;

typedef logic [15:0] lc3b_word;
typedef logic [2:0] lc3b_reg;
typedef logic [2:0] lc3b_nzp;

// signed so that plain assignment sign-extends
typedef logic signed [4:0] lc3b_imm5;
typedef logic signed [5:0] lc3b_offset6;
typedef logic signed [8:0] lc3b_offset9;

// lc3b encodings of the kept instructions
typedef enum logic [3:0] {
	op_br  = 4'b0000,
	op_add = 4'b0001,
	op_and = 4'b0101,
	op_ldr = 4'b0110,
	op_str = 4'b0111,
	op_not = 4'b1001
} lc3b_opcode;

typedef enum logic [1:0] {
	arb_idle,
	arb_ifetch,
	arb_data
} arb_state;

// ops that write a register and set the condition codes
function automatic logic writes_reg(input lc3b_opcode op);
	logic result;
	case (op)
		op_add, op_and, op_not, op_ldr: result = 1'b1;
		default: result = 1'b0;
	endcase
	return result;
endfunction

endpackage : lc3b_types

//--- logic/mem_access.sv
`timescale 1ns/1ns

module mem_access (
	input logic clk,
	input logic arst_n,

	input lc3b_types::lc3b_opcode em_op,
	input lc3b_types::lc3b_reg em_dr,
	input lc3b_types::lc3b_word em_result,
	input lc3b_types::lc3b_word em_address,
	input lc3b_types::lc3b_word em_store_data,
	input logic em_valid,

	input logic d_resp,
	input lc3b_types::lc3b_word d_rdata,

	output logic em_advance,
	output logic d_read,
	output logic d_write,
	output lc3b_types::lc3b_word d_address,
	output lc3b_types::lc3b_word d_wdata,

	output logic wb_en,
	output lc3b_types::lc3b_reg wb_dr,
	output lc3b_types::lc3b_word wb_data,
	output logic wb_cc_en
);

logic is_load;
logic is_store;
logic done;

assign is_load = (em_op == lc3b_types::op_ldr);
assign is_store = (em_op == lc3b_types::op_str);

// request held as a level until d_resp
assign d_read = em_valid && is_load;
assign d_write = em_valid && is_store;
assign d_address = em_address;
assign d_wdata = em_store_data;

assign done = !(is_load || is_store) || d_resp;
assign em_advance = !em_valid || done;

// every register writer here also sets cc
assign wb_cc_en = wb_en;

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n)
		wb_en <= 1'b0;
	else
		wb_en <= em_valid && done && lc3b_types::writes_reg(em_op);
end

always_ff @(posedge clk) begin
	wb_dr <= em_dr;
	wb_data <= is_load ? d_rdata : em_result;
end

endmodule : mem_access

//--- logic/mp3.sv
`timescale 1ns/1ns

module mp3 #(
	parameter lc3b_types::lc3b_word RESET_PC = 16'h0000
) (
	input logic clk,
	input logic arst_n,

	input logic pmem_resp,
	input lc3b_types::lc3b_word pmem_rdata,

	output logic pmem_read,
	output logic pmem_write,
	output lc3b_types::lc3b_word pmem_address,
	output lc3b_types::lc3b_word pmem_wdata
);

// fetch/decode
lc3b_types::lc3b_word fd_pc;
lc3b_types::lc3b_word fd_ir;
logic fd_valid;
logic fd_advance;

// decode/execute
lc3b_types::lc3b_word de_pc;
lc3b_types::lc3b_opcode de_op;
lc3b_types::lc3b_reg de_dr;
lc3b_types::lc3b_word de_sr1_val;
lc3b_types::lc3b_word de_sr2_val;
lc3b_types::lc3b_word de_imm;
lc3b_types::lc3b_nzp de_nzp;
logic de_valid;
logic de_advance;

// execute/memory
lc3b_types::lc3b_opcode em_op;
lc3b_types::lc3b_reg em_dr;
lc3b_types::lc3b_word em_result;
lc3b_types::lc3b_word em_address;
lc3b_types::lc3b_word em_store_data;
logic em_valid;
logic em_advance;

// branch redirect
logic br_taken;
lc3b_types::lc3b_word br_target;

// writeback
logic wb_en;
lc3b_types::lc3b_reg wb_dr;
lc3b_types::lc3b_word wb_data;
logic wb_cc_en;

// requesters toward the arbiter
logic if_read;
logic if_resp;
lc3b_types::lc3b_word if_address;
lc3b_types::lc3b_word if_rdata;
logic d_read;
logic d_write;
logic d_resp;
lc3b_types::lc3b_word d_address;
lc3b_types::lc3b_word d_wdata;
lc3b_types::lc3b_word d_rdata;

fetch #(.RESET_PC(RESET_PC)) fetch_i (
	.clk,
	.arst_n,
	.br_taken,
	.br_target,
	.fd_advance,
	.if_resp,
	.if_rdata,
	.if_read,
	.if_address,
	.fd_pc,
	.fd_ir,
	.fd_valid
);

decode decode_i (
	.clk,
	.arst_n,
	.fd_pc,
	.fd_ir,
	.fd_valid,
	.br_taken,
	.de_advance,
	.em_valid,
	.em_dr,
	.em_op,
	.wb_en,
	.wb_dr,
	.wb_data,
	.wb_cc_en,
	.fd_advance,
	.de_pc,
	.de_op,
	.de_dr,
	.de_sr1_val,
	.de_sr2_val,
	.de_imm,
	.de_nzp,
	.de_valid
);

execute execute_i (
	.clk,
	.arst_n,
	.de_pc,
	.de_op,
	.de_dr,
	.de_sr1_val,
	.de_sr2_val,
	.de_imm,
	.de_nzp,
	.de_valid,
	.em_advance,
	.de_advance,
	.br_taken,
	.br_target,
	.em_op,
	.em_dr,
	.em_result,
	.em_address,
	.em_store_data,
	.em_valid
);

mem_access mem_access_i (
	.clk,
	.arst_n,
	.em_op,
	.em_dr,
	.em_result,
	.em_address,
	.em_store_data,
	.em_valid,
	.d_resp,
	.d_rdata,
	.em_advance,
	.d_read,
	.d_write,
	.d_address,
	.d_wdata,
	.wb_en,
	.wb_dr,
	.wb_data,
	.wb_cc_en
);

arbiter arbiter_i (
	.clk,
	.arst_n,
	.if_read,
	.if_address,
	.d_read,
	.d_write,
	.d_address,
	.d_wdata,
	.pmem_resp,
	.pmem_rdata,
	.if_resp,
	.if_rdata,
	.d_resp,
	.d_rdata,
	.pmem_read,
	.pmem_write,
	.pmem_address,
	.pmem_wdata
);

endmodule : mp3
